// File: verilog/usb_in_settings.svh
// USB IN controller settings: endpoint count, packet size, ack timeout, counter width
`ifndef USB_IN_SETTINGS_SVH
`define USB_IN_SETTINGS_SVH

// Implemented IN endpoints, numbers 0 .. N-1
`define USB_IN_NUM_EPS 4

// Max bytes per packet, power of two
`define USB_IN_MAX_PKT 8

// Host handshake wait in 48 MHz clocks
// 17 bit times at 4 clocks each, plus 6 for rx SOP detection latency,
// minus 1 since the down counter stops at zero
`define USB_IN_ACK_TIMEOUT 73

`define USB_IN_CNT_W 8  // Event counter width

`endif

// File: verilog/usb_in_pkg.sv
// USB IN controller package: PID codes, field widths and shared structs
package usb_in_pkg;

  `include "usb_in_settings.svh"

  // 4-bit PID codes used on the IN side
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidIn    = 4'b1001,
    UsbPidSetup = 4'b1101,
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  // PID type lives in the two low bits
  typedef enum logic [1:0] {
    UsbPidTypeSpecial   = 2'b00,
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeHandshake = 2'b10,
    UsbPidTypeData      = 2'b11
  } usb_pid_type_e;

  typedef logic [3:0]                        ep_num_t;    // Endpoint number as on the bus
  typedef logic [`USB_IN_NUM_EPS-1:0]        ep_mask_t;   // One bit per endpoint
  typedef logic [6:0]                        dev_addr_t;
  typedef logic [$clog2(`USB_IN_MAX_PKT)-1:0] pkt_addr_t; // Byte offset in packet
  typedef logic [$clog2(`USB_IN_MAX_PKT):0]   pkt_len_t;  // 0 .. max packet
  typedef logic [7:0]                        byte_t;
  typedef logic [`USB_IN_CNT_W-1:0]          cnt_t;

  typedef struct packed {
    usb_pid_e  pid;
    dev_addr_t addr;
    ep_num_t   ep;
  } rx_tok_t;

  typedef struct packed {
    ep_mask_t enabled;
    ep_mask_t stall;
    ep_mask_t iso;
  } ep_ctrl_t;

  typedef struct packed {
    logic timeout;
    logic nak;
    logic nodata;
  } in_events_t;

endpackage

// File: verilog/usb_in_pe.sv
// USB IN protocol engine: token decode, DATA/NAK/STALL response, ack wait, data toggles
`timescale 1ns/1ps
`include "usb_in_settings.svh"

module usb_in_pe import usb_in_pkg::*; (
  input  logic       clk_48mhz_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       link_active_i,
  input  dev_addr_t  dev_addr_i,
  // rx path
  input  logic       rx_pkt_start_i,
  input  logic       rx_pkt_end_i,
  input  logic       rx_pkt_valid_i,
  input  rx_tok_t    rx_tok_i,
  // Endpoint interface
  input  ep_ctrl_t   ep_ctrl_i,
  input  ep_mask_t   has_data_i,
  input  ep_mask_t   data_done_i,
  input  byte_t      ep_data_i,
  output ep_num_t    ep_current_o,     // Endpoint of the running transaction
  output pkt_addr_t  get_addr_o,       // Byte offset being fetched
  output logic       newpkt_o,         // IN token seen, ep_current_o updates
  output logic       xact_end_o,       // Good end, packet delivered
  output logic       rollback_o,       // Bad end, packet kept for resend
  // Data toggles
  input  logic       datatog_we_i,
  input  ep_mask_t   datatog_mask_i,
  input  ep_mask_t   datatog_status_i,
  output ep_mask_t   data_toggle_o,
  // tx path
  output logic       tx_pkt_start_o,
  output usb_pid_e   tx_pid_o,
  input  logic       tx_pkt_end_i,
  output logic       tx_data_avail_o,
  input  logic       tx_data_get_i,
  output byte_t      tx_data_o,
  // Event strobes
  output in_events_t events_o
);

  localparam int unsigned EpIdxW  = $clog2(`USB_IN_NUM_EPS);
  localparam int unsigned AckCntW = $clog2(`USB_IN_ACK_TIMEOUT);

  typedef enum logic [2:0] {
    StIdle,
    StRcvdIn,
    StSendData,
    StWaitTxEnd,
    StWaitAckStart,
    StWaitAck
  } in_state_e;

  in_state_e        state_q, state_d;
  ep_mask_t         toggle_q, toggle_d;
  logic [AckCntW-1:0] ack_cnt_q, ack_cnt_d;
  logic             has_data_q;        // Packet was ready when the IN arrived
  logic             rollback_d;
  in_events_t       events_q;
  logic             token_rcvd, setup_rcvd, in_rcvd, ack_rcvd, nak_rcvd;
  logic             ep_in_hw, ep_active, in_starting, more_data;
  ep_num_t          ep_current_d;
  logic [EpIdxW-1:0] ep_idx, ep_idx_d;
  usb_pid_type_e    rx_pid_type;

  //////////////////////////////////////////////////
  // Token and handshake decode
  //////////////////////////////////////////////////

  assign rx_pid_type = usb_pid_type_e'(rx_tok_i.pid[1:0]);

  assign token_rcvd = rx_pkt_end_i && rx_pkt_valid_i &&
                      rx_pid_type == UsbPidTypeToken && rx_tok_i.addr == dev_addr_i;
  assign setup_rcvd = token_rcvd && rx_tok_i.pid == UsbPidSetup;
  assign in_rcvd    = token_rcvd && rx_tok_i.pid == UsbPidIn;
  assign ack_rcvd   = rx_pkt_end_i && rx_pkt_valid_i && rx_tok_i.pid == UsbPidAck;
  assign nak_rcvd   = rx_pkt_end_i && rx_pkt_valid_i && rx_tok_i.pid == UsbPidNak;

  // Numbers past the implemented range get no response
  assign ep_in_hw     = {1'b0, rx_tok_i.ep} < 5'(`USB_IN_NUM_EPS);
  assign ep_current_d = ep_in_hw ? rx_tok_i.ep : '0;
  assign ep_idx_d     = ep_current_d[EpIdxW-1:0];
  assign ep_idx       = ep_current_o[EpIdxW-1:0];
  assign ep_active    = ep_in_hw & ep_ctrl_i.enabled[ep_idx_d];

  assign in_starting = (state_q == StIdle || state_q == StWaitAck) && in_rcvd;

  assign more_data       = has_data_q & ~data_done_i[ep_idx];
  assign tx_data_avail_o = (state_q == StSendData) & more_data;

  //////////////////////////////////////////////////
  // Transaction FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    xact_end_o     = 1'b0;
    tx_pkt_start_o = 1'b0;
    tx_pid_o       = UsbPidNak;
    rollback_d     = 1'b0;
    ack_cnt_d      = AckCntW'(`USB_IN_ACK_TIMEOUT);  // Reload outside the ack wait
    unique case (state_q)
      StIdle: begin
        if (ep_active && in_rcvd) state_d = StRcvdIn;
      end
      StRcvdIn: begin
        tx_pkt_start_o = 1'b1;
        if (ep_ctrl_i.iso[ep_idx]) begin
          state_d  = StSendData;   // Iso always sends, zero length if empty
          tx_pid_o = UsbPidData0;
        end else if (ep_ctrl_i.stall[ep_idx]) begin
          state_d  = StIdle;
          tx_pid_o = UsbPidStall;
        end else if (has_data_q) begin
          state_d  = StSendData;
          tx_pid_o = toggle_q[ep_idx] ? UsbPidData1 : UsbPidData0;
        end else begin
          state_d  = StIdle;
          tx_pid_o = UsbPidNak;
        end
      end
      StSendData: begin
        // Out of bytes, or last byte of a full packet taken
        if (!more_data || ((&get_addr_o) && tx_data_get_i)) begin
          if (ep_ctrl_i.iso[ep_idx]) begin
            state_d    = StIdle;       // No handshake for iso
            xact_end_o = 1'b1;
          end else if (tx_pkt_end_i) begin
            state_d = StWaitAckStart;
          end else begin
            state_d = StWaitTxEnd;
          end
        end
      end
      StWaitTxEnd: begin
        if (tx_pkt_end_i) state_d = StWaitAckStart;
      end
      StWaitAckStart: begin
        ack_cnt_d = ack_cnt_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = StWaitAck;
        end else if (ack_cnt_q == '0) begin
          state_d    = StIdle;         // Host never answered
          rollback_d = 1'b1;
        end
      end
      StWaitAck: begin
        if (ack_rcvd) begin
          state_d    = StIdle;
          xact_end_o = 1'b1;
        end else if (in_rcvd) begin
          state_d    = ep_active ? StRcvdIn : StIdle;  // Handshake got lost
          rollback_d = 1'b1;
        end else if (rx_pkt_end_i) begin
          state_d    = StIdle;         // NAK or garbage
          rollback_d = 1'b1;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      ack_cnt_q  <= AckCntW'(`USB_IN_ACK_TIMEOUT);
      rollback_o <= 1'b0;
      events_q   <= '0;
    end else if (link_reset_i || !link_active_i) begin
      state_q    <= StIdle;              // Held idle while link is down
      ack_cnt_q  <= AckCntW'(`USB_IN_ACK_TIMEOUT);
      rollback_o <= 1'b0;
      events_q   <= '0;
    end else begin
      state_q    <= state_d;
      ack_cnt_q  <= ack_cnt_d;
      rollback_o <= rollback_d;
      // No handshake before the ack timeout
      events_q.timeout <= rollback_d & (state_q == StWaitAckStart);
      events_q.nak     <= (state_q == StWaitAck) && nak_rcvd;
      events_q.nodata  <= in_starting & ep_in_hw & ~has_data_i[ep_idx_d];
    end
  end

  assign events_o = events_q;

  //////////////////////////////////////////////////
  // Fetch address, current endpoint, tx byte
  //////////////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      get_addr_o <= '0;
    end else if (state_q == StIdle || state_q == StRcvdIn) begin
      get_addr_o <= '0;                    // Every packet starts at byte 0
    end else if (state_q == StSendData && tx_data_get_i) begin
      get_addr_o <= get_addr_o + 1'b1;
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ep_current_o <= '0;
      newpkt_o     <= 1'b0;
      has_data_q   <= 1'b0;
    end else begin
      newpkt_o <= in_rcvd;
      if (in_rcvd) begin
        ep_current_o <= ep_current_d;
        has_data_q   <= has_data_i[ep_idx_d];  // Snapshot at token time
      end
    end
  end

  // Byte at get address, one cycle behind
  always_ff @(posedge clk_48mhz_i) begin
    tx_data_o <= ep_data_i;
  end

  //////////////////////////////////////////////////
  // Data toggles
  //////////////////////////////////////////////////

  always_comb begin
    toggle_d = toggle_q;
    if (setup_rcvd && ep_active) begin
      toggle_d[ep_idx_d] = 1'b1;               // SETUP restarts with DATA1
    end else if (state_q == StWaitAck && ack_rcvd) begin
      toggle_d[ep_idx] = ~toggle_q[ep_idx];
    end
    // Software write wins on masked bits
    if (datatog_we_i) begin
      toggle_d = (toggle_d & ~datatog_mask_i) | (datatog_status_i & datatog_mask_i);
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;
    end else begin
      toggle_q <= toggle_d;
    end
  end

  assign data_toggle_o = toggle_q;

endmodule

// File: verilog/usb_in_ep_store.sv
// IN packet store: one packet per endpoint, lengths, ready flags, end-of-data detect
`timescale 1ns/1ps
`include "usb_in_settings.svh"

module usb_in_ep_store import usb_in_pkg::*; (
  input  logic      clk_48mhz_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  // Software side
  input  logic      wr_en_i,
  input  ep_num_t   wr_ep_i,
  input  pkt_addr_t wr_addr_i,
  input  byte_t     wr_data_i,
  input  logic      pkt_ready_i,      // Packet for pkt_ready_ep_i is complete
  input  ep_num_t   pkt_ready_ep_i,
  input  pkt_len_t  pkt_len_i,
  // Engine side
  input  ep_num_t   ep_current_i,
  input  pkt_addr_t get_addr_i,
  input  logic      xact_end_i,
  output ep_mask_t  has_data_o,
  output ep_mask_t  data_done_o,
  output byte_t     ep_data_o,
  output logic      pkt_sent_o
);

  localparam int unsigned EpIdxW = $clog2(`USB_IN_NUM_EPS);

  byte_t    mem [`USB_IN_NUM_EPS][`USB_IN_MAX_PKT];
  pkt_len_t len_q [`USB_IN_NUM_EPS];
  ep_mask_t ready_q;
  logic [EpIdxW-1:0] cur_idx;
  logic     wr_ep_ok, rdy_ep_ok;

  assign cur_idx   = ep_current_i[EpIdxW-1:0];  // Engine only passes implemented eps
  assign wr_ep_ok  = {1'b0, wr_ep_i} < 5'(`USB_IN_NUM_EPS);
  assign rdy_ep_ok = {1'b0, pkt_ready_ep_i} < 5'(`USB_IN_NUM_EPS);

  always_ff @(posedge clk_48mhz_i) begin
    if (wr_en_i && wr_ep_ok) mem[wr_ep_i[EpIdxW-1:0]][wr_addr_i] <= wr_data_i;
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q    <= '0;
      len_q      <= '{default: '0};
      pkt_sent_o <= 1'b0;
    end else begin
      // Only a packet actually held counts as sent
      pkt_sent_o <= xact_end_i & ready_q[cur_idx];
      if (link_reset_i) begin
        ready_q <= '0;
      end else begin
        if (xact_end_i) ready_q[cur_idx] <= 1'b0;
        if (pkt_ready_i && rdy_ep_ok) begin
          ready_q[pkt_ready_ep_i[EpIdxW-1:0]] <= 1'b1;  // Length 0 gives a ZLP
          len_q[pkt_ready_ep_i[EpIdxW-1:0]]   <= pkt_len_i;
        end
      end
    end
  end

  assign has_data_o = ready_q;

  // Done once the fetch offset reaches the stored length
  always_comb begin
    for (int i = 0; i < `USB_IN_NUM_EPS; i++) begin
      data_done_o[i] = {1'b0, get_addr_i} >= len_q[i];
    end
  end

  assign ep_data_o = mem[cur_idx][get_addr_i];

endmodule

// File: verilog/usb_in_event_cnt.sv
// IN event counters: saturating timeout, host NAK and no-data counts with clear
`timescale 1ns/1ps

module usb_in_event_cnt import usb_in_pkg::*; (
  input  logic       clk_48mhz_i,
  input  logic       rst_ni,
  input  in_events_t events_i,
  input  logic       clr_i,           // Zero all three counts
  output cnt_t       cnt_timeout_o,
  output cnt_t       cnt_nak_o,
  output cnt_t       cnt_nodata_o
);

  // Step up by one, stick at all ones
  function automatic cnt_t sat_inc(cnt_t cnt, logic ev);
    if (ev && !(&cnt)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_timeout_o <= '0;
      cnt_nak_o     <= '0;
      cnt_nodata_o  <= '0;
    end else if (clr_i) begin
      cnt_timeout_o <= '0;
      cnt_nak_o     <= '0;
      cnt_nodata_o  <= '0;
    end else begin
      cnt_timeout_o <= sat_inc(cnt_timeout_o, events_i.timeout);
      cnt_nak_o     <= sat_inc(cnt_nak_o, events_i.nak);
      cnt_nodata_o  <= sat_inc(cnt_nodata_o, events_i.nodata);
    end
  end

endmodule

// File: verilog/usb_in_top.sv
// USB IN controller top: protocol engine, packet store and event counters
`timescale 1ns/1ps

module usb_in_top import usb_in_pkg::*; (
  input  logic      clk_48mhz_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      link_active_i,
  input  dev_addr_t dev_addr_i,
  input  ep_ctrl_t  ep_ctrl_i,
  // Token receiver
  input  logic      rx_pkt_start_i,
  input  logic      rx_pkt_end_i,
  input  logic      rx_pkt_valid_i,
  input  rx_tok_t   rx_tok_i,
  // Transmitter
  output logic      tx_pkt_start_o,
  output usb_pid_e  tx_pid_o,
  input  logic      tx_pkt_end_i,
  output logic      tx_data_avail_o,
  input  logic      tx_data_get_i,
  output byte_t     tx_data_o,
  // Software packet write
  input  logic      wr_en_i,
  input  ep_num_t   wr_ep_i,
  input  pkt_addr_t wr_addr_i,
  input  byte_t     wr_data_i,
  input  logic      pkt_ready_i,
  input  ep_num_t   pkt_ready_ep_i,
  input  pkt_len_t  pkt_len_i,
  output logic      pkt_sent_o,
  // Toggles and counters
  input  logic      datatog_we_i,
  input  ep_mask_t  datatog_mask_i,
  input  ep_mask_t  datatog_status_i,
  output ep_mask_t  data_toggle_o,
  input  logic      cnt_clr_i,
  output cnt_t      cnt_timeout_o,
  output cnt_t      cnt_nak_o,
  output cnt_t      cnt_nodata_o
);

  ep_num_t    ep_current;
  pkt_addr_t  get_addr;
  logic       xact_end;
  ep_mask_t   has_data, data_done;
  byte_t      ep_data;
  in_events_t events;

  // Store keeps its packet across a rollback, so newpkt and rollback stay open
  usb_in_pe usb_in_pe_i (
    .clk_48mhz_i      (clk_48mhz_i),
    .rst_ni           (rst_ni),
    .link_reset_i     (link_reset_i),
    .link_active_i    (link_active_i),
    .dev_addr_i       (dev_addr_i),
    .rx_pkt_start_i   (rx_pkt_start_i),
    .rx_pkt_end_i     (rx_pkt_end_i),
    .rx_pkt_valid_i   (rx_pkt_valid_i),
    .rx_tok_i         (rx_tok_i),
    .ep_ctrl_i        (ep_ctrl_i),
    .has_data_i       (has_data),
    .data_done_i      (data_done),
    .ep_data_i        (ep_data),
    .ep_current_o     (ep_current),
    .get_addr_o       (get_addr),
    .newpkt_o         (),
    .xact_end_o       (xact_end),
    .rollback_o       (),
    .datatog_we_i     (datatog_we_i),
    .datatog_mask_i   (datatog_mask_i),
    .datatog_status_i (datatog_status_i),
    .data_toggle_o    (data_toggle_o),
    .tx_pkt_start_o   (tx_pkt_start_o),
    .tx_pid_o         (tx_pid_o),
    .tx_pkt_end_i     (tx_pkt_end_i),
    .tx_data_avail_o  (tx_data_avail_o),
    .tx_data_get_i    (tx_data_get_i),
    .tx_data_o        (tx_data_o),
    .events_o         (events)
  );

  usb_in_ep_store usb_in_ep_store_i (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .link_reset_i   (link_reset_i),
    .wr_en_i        (wr_en_i),
    .wr_ep_i        (wr_ep_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i),
    .pkt_ready_i    (pkt_ready_i),
    .pkt_ready_ep_i (pkt_ready_ep_i),
    .pkt_len_i      (pkt_len_i),
    .ep_current_i   (ep_current),
    .get_addr_i     (get_addr),
    .xact_end_i     (xact_end),
    .has_data_o     (has_data),
    .data_done_o    (data_done),
    .ep_data_o      (ep_data),
    .pkt_sent_o     (pkt_sent_o)
  );

  usb_in_event_cnt usb_in_event_cnt_i (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .events_i      (events),
    .clr_i         (cnt_clr_i),
    .cnt_timeout_o (cnt_timeout_o),
    .cnt_nak_o     (cnt_nak_o),
    .cnt_nodata_o  (cnt_nodata_o)
  );

endmodule

// File: testbench/usb_in_tb.sv
// Random testbench for the USB IN controller with host/PHY model and reference model
`timescale 1ns/1ps
`include "usb_in_settings.svh"

module usb_in_tb import usb_in_pkg::*; ();

  localparam int NumEps     = `USB_IN_NUM_EPS;
  localparam int MaxPkt     = `USB_IN_MAX_PKT;
  localparam int NumXact    = 120;
  localparam int CycleLimit = NumXact * 200;  // Worst transaction is a full ack timeout

  logic      clk_48mhz = 1'b0;
  logic      rst_n;
  logic      link_reset;
  logic      link_active;
  dev_addr_t dev_addr;
  ep_ctrl_t  ep_ctrl;
  logic      rx_pkt_start;
  logic      rx_pkt_end;
  logic      rx_pkt_valid;
  rx_tok_t   rx_tok;
  logic      tx_pkt_start;
  usb_pid_e  tx_pid;
  logic      tx_pkt_end;
  logic      tx_data_avail;
  logic      tx_data_get;
  byte_t     tx_data;
  logic      wr_en;
  ep_num_t   wr_ep;
  pkt_addr_t wr_addr;
  byte_t     wr_data;
  logic      pkt_ready;
  ep_num_t   pkt_ready_ep;
  pkt_len_t  pkt_len;
  logic      pkt_sent;
  logic      datatog_we;
  ep_mask_t  datatog_mask;
  ep_mask_t  datatog_status;
  ep_mask_t  data_toggle;
  logic      cnt_clr;
  cnt_t      cnt_timeout;
  cnt_t      cnt_nak;
  cnt_t      cnt_nodata;

  // Reference model state
  ep_ctrl_t  m_ctrl;
  ep_mask_t  m_tog;                      // Expected data toggles
  ep_mask_t  m_ready;                    // Packet waiting per endpoint
  pkt_len_t  m_len [NumEps];
  byte_t     m_mem [NumEps][MaxPkt];
  cnt_t      exp_timeout;
  cnt_t      exp_nak;
  cnt_t      exp_nodata;
  int        exp_sent;
  int        seen_sent;
  int        cycle_cnt;
  integer    seed;
  byte_t     rx_bytes [$];               // Bytes taken by the PHY model

  always #2 clk_48mhz = ~clk_48mhz;

  usb_in_top usb_in_top_i (
    .clk_48mhz_i      (clk_48mhz),
    .rst_ni           (rst_n),
    .link_reset_i     (link_reset),
    .link_active_i    (link_active),
    .dev_addr_i       (dev_addr),
    .ep_ctrl_i        (ep_ctrl),
    .rx_pkt_start_i   (rx_pkt_start),
    .rx_pkt_end_i     (rx_pkt_end),
    .rx_pkt_valid_i   (rx_pkt_valid),
    .rx_tok_i         (rx_tok),
    .tx_pkt_start_o   (tx_pkt_start),
    .tx_pid_o         (tx_pid),
    .tx_pkt_end_i     (tx_pkt_end),
    .tx_data_avail_o  (tx_data_avail),
    .tx_data_get_i    (tx_data_get),
    .tx_data_o        (tx_data),
    .wr_en_i          (wr_en),
    .wr_ep_i          (wr_ep),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .pkt_ready_i      (pkt_ready),
    .pkt_ready_ep_i   (pkt_ready_ep),
    .pkt_len_i        (pkt_len),
    .pkt_sent_o       (pkt_sent),
    .datatog_we_i     (datatog_we),
    .datatog_mask_i   (datatog_mask),
    .datatog_status_i (datatog_status),
    .data_toggle_o    (data_toggle),
    .cnt_clr_i        (cnt_clr),
    .cnt_timeout_o    (cnt_timeout),
    .cnt_nak_o        (cnt_nak),
    .cnt_nodata_o     (cnt_nodata)
  );

  //////////////////////////////////////////////////
  // Checks, monitors and run limit
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_pid(string name, usb_pid_e got, usb_pid_e exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(string name, byte_t got, byte_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mask(string name, ep_mask_t got, ep_mask_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cnt(string name, cnt_t got, cnt_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // Count pkt_sent_o pulses as seen at each edge
  always @(posedge clk_48mhz) begin
    if (pkt_sent === 1'b1) seen_sent <= seen_sent + 1;
  end

  always @(posedge clk_48mhz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("Error: run did not finish within %0d cycles", CycleLimit);
      abort_run();
    end
  end

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Saturating event count
  function automatic cnt_t count_event(cnt_t c);
    return (c == {`USB_IN_CNT_W{1'b1}}) ? c : cnt_t'(c + 1);
  endfunction

  //////////////////////////////////////////////////
  // Host, PHY and software side
  //////////////////////////////////////////////////

  task automatic send_token(usb_pid_e pid, dev_addr_t addr, ep_num_t ep);
    rx_tok       <= '{pid: pid, addr: addr, ep: ep};
    rx_pkt_end   <= 1'b1;
    rx_pkt_valid <= 1'b1;
    @(posedge clk_48mhz);                // DUT takes the token here
    rx_pkt_end   <= 1'b0;
    rx_pkt_valid <= 1'b0;
  endtask

  task automatic send_handshake(usb_pid_e pid);
    repeat (rand_below(8)) @(posedge clk_48mhz);
    rx_pkt_start <= 1'b1;
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b0;
    repeat (3) @(posedge clk_48mhz);     // Packet body on the wire
    send_token(pid, dev_addr, '0);
  endtask

  task automatic wait_start(output usb_pid_e pid);
    int waited;
    waited = 0;
    do begin
      @(posedge clk_48mhz);
      waited++;
    end while (tx_pkt_start !== 1'b1 && waited < 4);
    if (tx_pkt_start !== 1'b1) begin
      $display("Error: no tx_pkt_start_o within 4 cycles of a token that needs an answer");
      abort_run();
    end
    pid = tx_pid;
  endtask

  task automatic expect_silence();
    repeat (6) begin
      @(posedge clk_48mhz);
      if (tx_pkt_start !== 1'b0) begin
        $display("Error: tx_pkt_start_o pulsed for a token that needs no answer");
        abort_run();
      end
    end
  endtask

  // PHY takes bytes with gets two or more cycles apart, then ends the packet
  task automatic fetch_packet();
    rx_bytes.delete();
    @(posedge clk_48mhz);
    while (tx_data_avail === 1'b1) begin
      tx_data_get <= 1'b1;
      @(posedge clk_48mhz);
      tx_data_get <= 1'b0;
      rx_bytes.push_back(tx_data);       // Byte on the bus during the get
      repeat (rand_below(3) + 1) @(posedge clk_48mhz);
    end
    tx_pkt_end <= 1'b1;
    @(posedge clk_48mhz);
    tx_pkt_end <= 1'b0;
  endtask

  task automatic load_packet(int idx);
    int len;
    len = rand_below(MaxPkt + 1);        // Zero gives a ZLP
    for (int i = 0; i < len; i++) begin
      m_mem[idx][i] = byte_t'(rand_below(256));
      wr_en   <= 1'b1;
      wr_ep   <= ep_num_t'(idx);
      wr_addr <= pkt_addr_t'(i);
      wr_data <= m_mem[idx][i];
      @(posedge clk_48mhz);
    end
    wr_en        <= 1'b0;
    pkt_ready    <= 1'b1;
    pkt_ready_ep <= ep_num_t'(idx);
    pkt_len      <= pkt_len_t'(len);
    @(posedge clk_48mhz);
    pkt_ready    <= 1'b0;
    m_len[idx]   = pkt_len_t'(len);
    m_ready[idx] = 1'b1;
  endtask

  task automatic in_transfer(ep_num_t ep, dev_addr_t addr);
    usb_pid_e pid;
    usb_pid_e exp_pid;
    int       idx;
    int       exp_len;
    int       reply;
    logic     ours;
    ours = (addr == dev_addr) && (int'(ep) < NumEps);
    idx  = ours ? int'(ep) : 0;
    if (ours && !m_ready[idx]) exp_nodata = count_event(exp_nodata);
    send_token(UsbPidIn, addr, ep);
    if (!ours || !m_ctrl.enabled[idx]) begin
      expect_silence();
    end else begin
      if (m_ctrl.iso[idx]) exp_pid = UsbPidData0;        // Iso ignores the toggle
      else if (m_ctrl.stall[idx]) exp_pid = UsbPidStall;
      else if (m_ready[idx]) exp_pid = m_tog[idx] ? UsbPidData1 : UsbPidData0;
      else exp_pid = UsbPidNak;
      wait_start(pid);
      check_pid("tx_pid_o", pid, exp_pid);
      if (exp_pid == UsbPidData0 || exp_pid == UsbPidData1) begin
        fetch_packet();
        exp_len = m_ready[idx] ? int'(m_len[idx]) : 0;
        check_byte("tx byte count", byte_t'(rx_bytes.size()), byte_t'(exp_len));
        for (int i = 0; i < exp_len; i++) begin
          check_byte("tx_data_o", rx_bytes[i], m_mem[idx][i]);
        end
        if (m_ctrl.iso[idx]) begin
          if (m_ready[idx]) exp_sent++;  // Empty iso reply sends nothing
          m_ready[idx] = 1'b0;
        end else begin
          reply = rand_below(5);
          if (reply < 3) begin
            send_handshake(UsbPidAck);
            m_tog[idx]   = ~m_tog[idx];
            m_ready[idx] = 1'b0;
            exp_sent++;
          end else if (reply == 3) begin
            send_handshake(UsbPidNak);   // Rolled back, packet stays
            exp_nak = count_event(exp_nak);
          end else begin
            repeat (`USB_IN_ACK_TIMEOUT + 12) @(posedge clk_48mhz);
            exp_timeout = count_event(exp_timeout);
          end
        end
      end
    end
  endtask

  // Wait for things to settle, then compare toggles and counts
  task automatic check_state();
    repeat (4) @(posedge clk_48mhz);
    check_mask("data_toggle_o", data_toggle, m_tog);
    check_cnt("cnt_timeout_o", cnt_timeout, exp_timeout);
    check_cnt("cnt_nak_o", cnt_nak, exp_nak);
    check_cnt("cnt_nodata_o", cnt_nodata, exp_nodata);
    check_cnt("pkt_sent_o pulses", cnt_t'(seen_sent), cnt_t'(exp_sent));
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    ep_num_t   ep;
    dev_addr_t addr;
    ep_mask_t  mask;
    ep_mask_t  status;
    int        op;
    int        sel;
    seed           = 49208;
    rst_n          = 1'b0;
    link_reset     = 1'b0;
    link_active    = 1'b1;
    dev_addr       = dev_addr_t'($random(seed));
    rx_pkt_start   = 1'b0;
    rx_pkt_end     = 1'b0;
    rx_pkt_valid   = 1'b0;
    rx_tok         = '{pid: UsbPidOut, addr: '0, ep: '0};
    tx_pkt_end     = 1'b0;
    tx_data_get    = 1'b0;
    wr_en          = 1'b0;
    wr_ep          = '0;
    wr_addr        = '0;
    wr_data        = '0;
    pkt_ready      = 1'b0;
    pkt_ready_ep   = '0;
    pkt_len        = '0;
    datatog_we     = 1'b0;
    datatog_mask   = '0;
    datatog_status = '0;
    cnt_clr        = 1'b0;
    m_ctrl.enabled = '1;
    m_ctrl.stall   = '0;
    m_ctrl.iso     = ep_mask_t'(1 << 2);  // Endpoint 2 is isochronous
    ep_ctrl        = m_ctrl;
    m_tog          = '0;
    m_ready        = '0;
    exp_timeout    = '0;
    exp_nak        = '0;
    exp_nodata     = '0;
    exp_sent       = 0;
    seen_sent      = 0;
    cycle_cnt      = 0;
    repeat (16) @(posedge clk_48mhz);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk_48mhz);

    for (int n = 0; n < NumXact; n++) begin
      if (rand_below(4) == 0) begin      // New endpoint setup, stall only off iso
        m_ctrl.enabled = ~ep_mask_t'(rand_below(1 << NumEps) & rand_below(1 << NumEps)
                                     & rand_below(1 << NumEps));
        m_ctrl.stall   = ep_mask_t'(rand_below(1 << NumEps) & rand_below(1 << NumEps))
                         & ~m_ctrl.iso;
        ep_ctrl <= m_ctrl;
        @(posedge clk_48mhz);
      end
      sel  = rand_below(6);
      ep   = (sel < NumEps) ? ep_num_t'(sel) : ep_num_t'(NumEps + rand_below(16 - NumEps));
      addr = (rand_below(8) == 0) ? dev_addr ^ dev_addr_t'(1 + rand_below(127)) : dev_addr;
      op   = rand_below(16);
      if (op == 0) begin
        mask   = ep_mask_t'(rand_below(1 << NumEps));
        status = ep_mask_t'(rand_below(1 << NumEps));
        datatog_we     <= 1'b1;
        datatog_mask   <= mask;
        datatog_status <= status;
        @(posedge clk_48mhz);
        datatog_we     <= 1'b0;
        m_tog = (m_tog & ~mask) | (status & mask);  // Masked bits only
      end else if (op == 1) begin
        link_reset <= 1'b1;
        @(posedge clk_48mhz);
        link_reset <= 1'b0;
        m_tog   = '0;
        m_ready = '0;                    // Store drops all packets
      end else if (op == 2) begin
        cnt_clr <= 1'b1;
        @(posedge clk_48mhz);
        cnt_clr <= 1'b0;
        exp_timeout = '0;
        exp_nak     = '0;
        exp_nodata  = '0;
      end else if (op == 3) begin
        send_token(UsbPidSetup, dev_addr, ep);
        if (int'(ep) < NumEps && m_ctrl.enabled[ep]) m_tog[ep] = 1'b1;
        expect_silence();
      end else begin
        if (int'(ep) < NumEps && !m_ready[ep] && rand_below(2) == 0) load_packet(int'(ep));
        in_transfer(ep, addr);
      end
      check_state();
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+verilog
verilog/usb_in_pkg.sv
verilog/usb_in_pe.sv
verilog/usb_in_ep_store.sv
verilog/usb_in_event_cnt.sv
verilog/usb_in_top.sv
testbench/usb_in_tb.sv

// File: Bender.yml
package:
  name: usb_in

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/usb_in_pkg.sv
      - verilog/usb_in_pe.sv
      - verilog/usb_in_ep_store.sv
      - verilog/usb_in_event_cnt.sv
      - verilog/usb_in_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - testbench/usb_in_tb.sv
